// File: hdl/stepper_defines.svh
`ifndef STEPPER_DEFINES_SVH
`define STEPPER_DEFINES_SVH

// step counts, positions and stroke
`define STEP_NUMBER_WIDTH 16

// one table entry is a step period in ticks
`define STEP_SPEED_WIDTH 16

`define STEP_TABLE_AWIDTH 4
`define STEP_TABLE_DEPTH (1 << `STEP_TABLE_AWIDTH)

// microstep code for the driver
`define STEP_MS_WIDTH 3

// clocks per tick
`define STEP_CLK_DIV 5

// equal samples needed before the zero sensor output flips
`define STEP_ZPD_FILTER 4

`endif

// File: hdl/stepper_pkg.sv
`default_nettype none
`include "stepper_defines.svh"

package stepper_pkg;

	// host move command, sampled on start
	typedef struct packed {
		logic [`STEP_TABLE_AWIDTH-1:0] speed;
		logic [`STEP_NUMBER_WIDTH-1:0] step;
		logic                          dir;
		logic [`STEP_MS_WIDTH-1:0]     ms;
	} motion_cmd_t;

	// sequencer to speed table
	typedef struct packed {
		logic [`STEP_TABLE_AWIDTH-1:0] idx;
		logic                          dir;
		logic                          last;
	} step_req_t;

	// speed table to pulse generator
	typedef struct packed {
		logic [`STEP_SPEED_WIDTH-1:0] period;
		logic                         dir;
		logic                         last;
	} step_cmd_t;

endpackage

`default_nettype wire

// File: hdl/speed_table.sv
`default_nettype none
`include "stepper_defines.svh"

module speed_table #(
	parameter int MOTOR_NBR = 2
) (
	input  wire                          clk,
	input  wire                          resetn,
	input  wire                          br_init,
	input  wire                          br_wr_en,
	input  wire [`STEP_SPEED_WIDTH-1:0]  br_data,
	input  wire stepper_pkg::step_req_t  req [MOTOR_NBR],
	input  wire [MOTOR_NBR-1:0]          req_valid,
	output logic [MOTOR_NBR-1:0]         req_ready,
	output stepper_pkg::step_cmd_t       rsp [MOTOR_NBR],
	output logic [MOTOR_NBR-1:0]         rsp_valid,
	input  wire [MOTOR_NBR-1:0]          rsp_ready
);
	localparam int RW = (MOTOR_NBR > 1) ? $clog2(MOTOR_NBR) : 1;

	logic [`STEP_SPEED_WIDTH-1:0] table_mem [`STEP_TABLE_DEPTH];
	logic [`STEP_TABLE_AWIDTH-1:0] wr_ptr;
	logic [`STEP_TABLE_AWIDTH-1:0] wr_addr;
	logic init_q;
	logic init_rise;
	logic [MOTOR_NBR-1:0] elig;
	logic [MOTOR_NBR-1:0] grant;
	logic [RW-1:0] rr;
	logic [RW-1:0] gnt_idx;
	logic gnt_any;

	// a fresh init starts loading at entry 0
	assign init_rise = br_init && !init_q;
	assign wr_addr = init_rise ? '0 : wr_ptr;

	// motor can be served once its response slot is free or draining
	assign elig = br_init ? '0 : (req_valid & (~rsp_valid | rsp_ready));
	assign req_ready = grant;

	always_comb begin
		int j;
		grant = '0;
		gnt_idx = rr;
		gnt_any = 1'b0;
		for (int k = 0; k < MOTOR_NBR; k++) begin
			j = (int'(rr) + k) % MOTOR_NBR;
			if (!gnt_any && elig[j]) begin
				grant[j] = 1'b1;
				gnt_idx = RW'(j);
				gnt_any = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			init_q <= 1'b0;
			wr_ptr <= '0;
			rr <= '0;
			rsp_valid <= '0;
		end else begin
			init_q <= br_init;
			if (br_init && br_wr_en)
				wr_ptr <= wr_addr + 1'b1;
			else if (init_rise)
				wr_ptr <= '0;
			if (gnt_any)
				rr <= RW'((int'(gnt_idx) + 1) % MOTOR_NBR);
			for (int i = 0; i < MOTOR_NBR; i++) begin
				if (grant[i])
					rsp_valid[i] <= 1'b1;
				else if (rsp_ready[i])
					rsp_valid[i] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (br_init && br_wr_en)
			table_mem[wr_addr] <= br_data;
		for (int i = 0; i < MOTOR_NBR; i++) begin
			if (grant[i]) begin
				rsp[i].period <= table_mem[req[i].idx];
				rsp[i].dir <= req[i].dir;
				rsp[i].last <= req[i].last;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!resetn) $onehot0(grant));

endmodule

`default_nettype wire

// File: hdl/motion_sequencer.sv
`default_nettype none
`include "stepper_defines.svh"

module motion_sequencer (
	input  wire                              clk,
	input  wire                              resetn,
	input  wire stepper_pkg::motion_cmd_t    cmd,
	input  wire                              start,
	input  wire                              stop,
	input  wire [`STEP_NUMBER_WIDTH-1:0]     stroke,
	input  wire                              zpd_raw,
	output stepper_pkg::step_req_t           req,
	output logic                             req_valid,
	input  wire                              req_ready,
	input  wire                              step_done,
	output logic                             busy,
	output logic                             zpsign,
	output logic                             tpsign,
	output logic                             dir_out,
	output logic [`STEP_MS_WIDTH-1:0]        ms_out
);
	import stepper_pkg::*;

	localparam int NW = `STEP_NUMBER_WIDTH;
	localparam int TA = `STEP_TABLE_AWIDTH;
	localparam int FW = $clog2(`STEP_ZPD_FILTER + 1);

	logic [NW-1:0] total_q;
	logic [TA-1:0] cap_q;
	logic [NW-1:0] issued;
	logic [NW-1:0] finished;
	logic [NW-1:0] position;
	logic [NW-1:0] remain;
	logic [NW-1:0] inflight;
	logic [NW:0] reach;
	logic halt_q;
	logic zp_block;
	logic tp_block;
	logic more;
	logic drained;
	logic can_issue;
	logic zpd_q;
	logic [FW-1:0] zpd_cnt;
	step_req_t next_req;

	// trapezoid entry: min(k, r - 1, cap)
	function automatic logic [TA-1:0] profile_idx(input logic [NW-1:0] k,
			input logic [NW-1:0] r, input logic [TA-1:0] cap);
		logic [NW-1:0] m;
		logic [NW-1:0] cap_w;
		cap_w = {{(NW - TA){1'b0}}, cap};
		m = (k < r - 1'b1) ? k : r - 1'b1;
		if (m > cap_w)
			m = cap_w;
		return m[TA-1:0];
	endfunction

	assign remain = total_q - issued;
	assign inflight = issued - finished;
	// position the motor reaches once everything issued has played
	assign reach = {1'b0, position} + {1'b0, inflight};
	assign zp_block = !dir_out && zpsign;
	assign tp_block = dir_out && (reach >= {1'b0, stroke});
	assign more = !halt_q && !zp_block && !tp_block && (issued != total_q);
	assign drained = !req_valid && ((inflight == '0) || (step_done && inflight == NW'(1)));
	// at most two steps per motor in flight
	assign can_issue = busy && more && !req_valid && (inflight < NW'(2));
	assign tpsign = (position == stroke);

	always_comb begin
		next_req.idx = profile_idx(issued, remain, cap_q);
		next_req.dir = dir_out;
		next_req.last = (remain == NW'(1));
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			req_valid <= 1'b0;
			issued <= '0;
			finished <= '0;
			halt_q <= 1'b0;
			position <= '0;
			dir_out <= 1'b0;
			ms_out <= '0;
		end else begin
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
					issued <= '0;
					finished <= '0;
					halt_q <= 1'b0;
					dir_out <= cmd.dir;
					ms_out <= cmd.ms;
				end
			end else begin
				if (stop)
					halt_q <= 1'b1;
				if (!more && drained)
					busy <= 1'b0;
				if (can_issue) begin
					req_valid <= 1'b1;
					issued <= issued + 1'b1;
				end else if (req_valid && req_ready) begin
					req_valid <= 1'b0;
				end
				if (step_done)
					finished <= finished + 1'b1;
			end
			// homing pins the position at zero
			if (busy && zp_block)
				position <= '0;
			else if (step_done)
				position <= dir_out ? position + 1'b1 : position - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && start) begin
			total_q <= cmd.step;
			cap_q <= cmd.speed;
		end
		if (can_issue)
			req <= next_req;
	end

	// zero sensor glitch filter
	always_ff @(posedge clk) begin
		if (!resetn) begin
			zpd_q <= 1'b0;
			zpd_cnt <= '0;
			zpsign <= 1'b0;
		end else begin
			zpd_q <= zpd_raw;
			if (zpd_q == zpsign) begin
				zpd_cnt <= '0;
			end else if (zpd_cnt == FW'(`STEP_ZPD_FILTER - 1)) begin
				zpsign <= zpd_q;
				zpd_cnt <= '0;
			end else begin
				zpd_cnt <= zpd_cnt + 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!resetn)
		req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

`default_nettype wire

// File: hdl/pulse_generator.sv
`default_nettype none
`include "stepper_defines.svh"

module pulse_generator (
	input  wire                          clk,
	input  wire                          resetn,
	input  wire stepper_pkg::step_cmd_t  cmd,
	input  wire                          cmd_valid,
	output logic                         cmd_ready,
	output logic                         drive,
	output logic                         step_done,
	output logic                         done_last
);
	localparam int DW = (`STEP_CLK_DIV > 1) ? $clog2(`STEP_CLK_DIV) : 1;

	logic active;
	logic [DW-1:0] div_cnt;
	logic [`STEP_SPEED_WIDTH-1:0] per_cnt;
	logic last_q;
	logic tick;
	logic step_end;
	logic take;

	// divider restarts with every step so edges stay period aligned
	assign tick = active && (div_cnt == DW'(`STEP_CLK_DIV - 1));
	assign step_end = tick && (per_cnt == `STEP_SPEED_WIDTH'(1));

	// next step only at a boundary
	assign cmd_ready = !active || step_end;
	assign take = cmd_valid && cmd_ready;
	assign step_done = step_end;
	assign done_last = step_end && last_q;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			div_cnt <= '0;
			per_cnt <= '0;
			drive <= 1'b0;
		end else if (take) begin
			active <= 1'b1;
			div_cnt <= '0;
			per_cnt <= cmd.period;
			drive <= 1'b1;
		end else begin
			if (step_end)
				active <= 1'b0;
			if (active)
				div_cnt <= tick ? '0 : div_cnt + 1'b1;
			// pulse lasts the first tick of the step
			if (tick) begin
				per_cnt <= per_cnt - 1'b1;
				drive <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			last_q <= cmd.last;
	end

	assert property (@(posedge clk) disable iff (!resetn)
		$rose(drive) |-> ##[1:`STEP_CLK_DIV] !drive);

endmodule

`default_nettype wire

// File: hdl/step_motor.sv
`default_nettype none
`include "stepper_defines.svh"

module step_motor #(
	parameter int MOTOR_NBR = 2
) (
	input  wire                              clk,
	input  wire                              resetn,
	input  wire                              br_init,
	input  wire                              br_wr_en,
	input  wire [`STEP_SPEED_WIDTH-1:0]      br_data,
	input  wire [MOTOR_NBR-1:0]              m_zpd,
	output wire [MOTOR_NBR-1:0]              m_drive,
	output wire [MOTOR_NBR-1:0]              m_dir,
	output wire [`STEP_MS_WIDTH-1:0]         m_ms [MOTOR_NBR],
	output logic [MOTOR_NBR-1:0]             m_xen,
	output logic [MOTOR_NBR-1:0]             m_xrst,
	output wire [MOTOR_NBR-1:0]              s_zpsign,
	output wire [MOTOR_NBR-1:0]              s_tpsign,
	input  wire [`STEP_NUMBER_WIDTH-1:0]     s_stroke [MOTOR_NBR],
	input  wire stepper_pkg::motion_cmd_t    s_cmd [MOTOR_NBR],
	input  wire [MOTOR_NBR-1:0]              s_start,
	input  wire [MOTOR_NBR-1:0]              s_stop,
	output wire [MOTOR_NBR-1:0]              s_state,
	input  wire [MOTOR_NBR-1:0]              s_xen,
	input  wire [MOTOR_NBR-1:0]              s_xrst
);
	import stepper_pkg::*;

	step_req_t req [MOTOR_NBR];
	step_cmd_t rsp [MOTOR_NBR];
	logic [MOTOR_NBR-1:0] req_valid;
	logic [MOTOR_NBR-1:0] req_ready;
	logic [MOTOR_NBR-1:0] rsp_valid;
	logic [MOTOR_NBR-1:0] rsp_ready;
	logic [MOTOR_NBR-1:0] step_done;
	logic [MOTOR_NBR-1:0] done_last;

	// driver enable and reset lines
	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_xen <= '0;
			m_xrst <= '0;
		end else begin
			m_xen <= s_xen;
			m_xrst <= s_xrst;
		end
	end

	speed_table #(
		.MOTOR_NBR (MOTOR_NBR)
	) i_speed_table (
		.clk       (clk),
		.resetn    (resetn),
		.br_init   (br_init),
		.br_wr_en  (br_wr_en),
		.br_data   (br_data),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.rsp       (rsp),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready)
	);

	for (genvar i = 0; i < MOTOR_NBR; i++) begin : g_motor
		motion_sequencer i_motion_sequencer (
			.clk       (clk),
			.resetn    (resetn),
			.cmd       (s_cmd[i]),
			.start     (s_start[i]),
			.stop      (s_stop[i]),
			.stroke    (s_stroke[i]),
			.zpd_raw   (m_zpd[i]),
			.req       (req[i]),
			.req_valid (req_valid[i]),
			.req_ready (req_ready[i]),
			.step_done (step_done[i]),
			.busy      (s_state[i]),
			.zpsign    (s_zpsign[i]),
			.tpsign    (s_tpsign[i]),
			.dir_out   (m_dir[i]),
			.ms_out    (m_ms[i])
		);

		pulse_generator i_pulse_generator (
			.clk       (clk),
			.resetn    (resetn),
			.cmd       (rsp[i]),
			.cmd_valid (rsp_valid[i]),
			.cmd_ready (rsp_ready[i]),
			.drive     (m_drive[i]),
			.step_done (step_done[i]),
			.done_last (done_last[i])
		);

		// the step flagged last by the sequencer closes the move
		assert property (@(posedge clk) disable iff (!resetn)
			done_last[i] |=> !s_state[i]);
	end

endmodule

`default_nettype wire

// File: dv/step_motor_tb.sv
`default_nettype none
`include "stepper_defines.svh"

module step_motor_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import stepper_pkg::*;

	localparam int MOTOR_NBR = 2;
	localparam int CLK_PERIOD = 20;
	localparam int DIV = `STEP_CLK_DIV;
	localparam int NW = `STEP_NUMBER_WIDTH;
	localparam int SW = `STEP_SPEED_WIDTH;
	localparam int TA = `STEP_TABLE_AWIDTH;
	localparam int MW = `STEP_MS_WIDTH;
	localparam int MAX_EDGES = 256;
	// slowest step is 30 ticks and the longest single move is 100 steps
	localparam int IDLE_LIMIT = 100 * 30 * DIV + 100;
	localparam int TOTAL_STEPS = 10 + 12 + 40 + 100 + 20 + 2 * 20;
	localparam int WATCHDOG_NS = TOTAL_STEPS * 30 * DIV * CLK_PERIOD + 50000;

	logic clk;
	logic resetn;
	logic br_init;
	logic br_wr_en;
	logic [SW-1:0] br_data;
	logic [MOTOR_NBR-1:0] m_zpd;
	wire [MOTOR_NBR-1:0] m_drive;
	wire [MOTOR_NBR-1:0] m_dir;
	wire [MW-1:0] m_ms [MOTOR_NBR];
	wire [MOTOR_NBR-1:0] m_xen;
	wire [MOTOR_NBR-1:0] m_xrst;
	wire [MOTOR_NBR-1:0] s_zpsign;
	wire [MOTOR_NBR-1:0] s_tpsign;
	logic [NW-1:0] s_stroke [MOTOR_NBR];
	motion_cmd_t s_cmd [MOTOR_NBR];
	logic [MOTOR_NBR-1:0] s_start;
	logic [MOTOR_NBR-1:0] s_stop;
	wire [MOTOR_NBR-1:0] s_state;
	logic [MOTOR_NBR-1:0] s_xen;
	logic [MOTOR_NBR-1:0] s_xrst;

	int cycle = 0;
	int edge_cnt [MOTOR_NBR] = '{default: 0};
	int edge_cyc [MOTOR_NBR][MAX_EDGES];
	logic [MOTOR_NBR-1:0] drive_q = '0;
	string test_name;
	int test_errors;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;

	step_motor #(
		.MOTOR_NBR (MOTOR_NBR)
	) i_step_motor (
		.clk      (clk),
		.resetn   (resetn),
		.br_init  (br_init),
		.br_wr_en (br_wr_en),
		.br_data  (br_data),
		.m_zpd    (m_zpd),
		.m_drive  (m_drive),
		.m_dir    (m_dir),
		.m_ms     (m_ms),
		.m_xen    (m_xen),
		.m_xrst   (m_xrst),
		.s_zpsign (s_zpsign),
		.s_tpsign (s_tpsign),
		.s_stroke (s_stroke),
		.s_cmd    (s_cmd),
		.s_start  (s_start),
		.s_stop   (s_stop),
		.s_state  (s_state),
		.s_xen    (s_xen),
		.s_xrst   (s_xrst)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	// rising edges of m_drive logged by clock cycle
	always @(posedge clk) begin
		for (int i = 0; i < MOTOR_NBR; i++) begin
			if (m_drive[i] && !drive_q[i]) begin
				if (edge_cnt[i] < MAX_EDGES)
					edge_cyc[i][edge_cnt[i]] = cycle;
				edge_cnt[i] = edge_cnt[i] + 1;
			end
		end
		drive_q = m_drive;
	end

	// table holds 30, 28, 26 and so on down to 2
	function automatic int table_entry(input int idx);
		return (30 - 2 * idx < 2) ? 2 : 30 - 2 * idx;
	endfunction

	// clocks from step k's rising edge to the next in an n step move
	function automatic int step_clocks(input int k, input int n, input int cap);
		int e;
		e = k;
		if (n - 1 - k < e)
			e = n - 1 - k;
		if (cap < e)
			e = cap;
		return table_entry(e) * DIV;
	endfunction

	task automatic note_failure(input string msg);
		test_errors++;
		$display("error in %s: %s", test_name, msg);
	endtask

	task automatic check_count(input string what, input logic [NW-1:0] expected,
			input logic [NW-1:0] actual);
		checks++;
		if (actual !== expected) begin
			test_errors++;
			$display("mismatch in %s: %s expected %0d, actual %0d", test_name, what,
				expected, actual);
		end
	endtask

	task automatic check_count_range(input string what, input logic [NW-1:0] lo,
			input logic [NW-1:0] hi, input logic [NW-1:0] actual);
		checks++;
		if (actual < lo || actual > hi) begin
			test_errors++;
			$display("mismatch in %s: %s expected %0d to %0d, actual %0d", test_name, what,
				lo, hi, actual);
		end
	endtask

	task automatic check_period(input string what, input logic [SW-1:0] expected,
			input logic [SW-1:0] actual);
		checks++;
		if (actual !== expected) begin
			test_errors++;
			$display("mismatch in %s: %s interval expected %0d, actual %0d", test_name,
				what, expected, actual);
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			test_errors++;
			$display("mismatch in %s: %s expected %0b, actual %0b", test_name, what,
				expected, actual);
		end
	endtask

	task automatic check_ms(input string what, input logic [MW-1:0] expected,
			input logic [MW-1:0] actual);
		checks++;
		if (actual !== expected) begin
			test_errors++;
			$display("mismatch in %s: %s expected %0d, actual %0d", test_name, what,
				expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic end_test();
		errors += test_errors;
		if (test_errors != 0)
			tests_failed++;
		$display("test %s: %s, %0d errors", test_name, (test_errors == 0) ? "passed" : "failed",
			test_errors);
	endtask

	task automatic load_table();
		@(posedge clk);
		br_init <= 1'b1;
		for (int i = 0; i < `STEP_TABLE_DEPTH; i++) begin
			@(posedge clk);
			br_wr_en <= 1'b1;
			br_data <= SW'(table_entry(i));
		end
		@(posedge clk);
		br_wr_en <= 1'b0;
		br_init <= 1'b0;
	endtask

	task automatic set_cmd(input int m, input int steps, input int cap, input logic dir);
		motion_cmd_t c;
		c.speed = TA'(cap);
		c.step = NW'(steps);
		c.dir = dir;
		c.ms = MW'(m + 1);
		@(posedge clk);
		s_cmd[m] <= c;
	endtask

	task automatic pulse_start(input logic [MOTOR_NBR-1:0] mask);
		@(posedge clk);
		s_start <= mask;
		@(posedge clk);
		s_start <= '0;
	endtask

	task automatic wait_idle(input int m);
		int n;
		n = 0;
		@(negedge clk);
		while (s_state[m] && n < IDLE_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (s_state[m])
			note_failure($sformatf("motor %0d still busy after %0d cycles", m, n));
	endtask

	task automatic wait_edges(input int m, input int target);
		int n;
		n = 0;
		while (edge_cnt[m] < target && n < IDLE_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (edge_cnt[m] < target)
			note_failure($sformatf("motor %0d gave no step pulse for %0d cycles", m, n));
	endtask

	task automatic check_intervals(input int m, input int base, input int n, input int cap);
		int gap;
		for (int k = 0; k + 1 < n; k++) begin
			gap = edge_cyc[m][base + k + 1] - edge_cyc[m][base + k];
			check_period($sformatf("motor %0d step %0d", m, k), SW'(step_clocks(k, n, cap)),
				SW'(gap));
		end
	endtask

	task automatic single_move();
		int base;
		int fall;
		int last;
		begin_test("single move");
		base = edge_cnt[0];
		set_cmd(0, 10, 15, 1'b1);
		pulse_start(2'b01);
		wait_idle(0);
		fall = cycle;
		check_count("pulses", NW'(10), NW'(edge_cnt[0] - base));
		last = edge_cyc[0][edge_cnt[0] - 1];
		// state drops once the last step has played out
		check_period("state fall after last step", SW'(step_clocks(9, 10, 15)),
			SW'(fall - last));
		check_bit("dir", 1'b1, m_dir[0]);
		check_ms("microstep", MW'(1), m_ms[0]);
		check_bit("driver enable", 1'b1, m_xen[0]);
		@(posedge clk);
		s_xrst <= 2'b01;
		@(posedge clk);
		@(negedge clk);
		check_bit("driver reset 0", 1'b1, m_xrst[0]);
		check_bit("driver reset 1", 1'b0, m_xrst[1]);
		@(posedge clk);
		s_xrst <= '0;
		repeat (200) @(negedge clk);
		check_count("pulses after idle", NW'(10), NW'(edge_cnt[0] - base));
		end_test();
	endtask

	task automatic profile_timing();
		int base;
		begin_test("profile timing");
		base = edge_cnt[0];
		set_cmd(0, 12, 3, 1'b1);
		pulse_start(2'b01);
		wait_idle(0);
		check_count("pulses", NW'(12), NW'(edge_cnt[0] - base));
		if (edge_cnt[0] - base == 12)
			check_intervals(0, base, 12, 3);
		end_test();
	endtask

	task automatic stop_mid_move();
		int base;
		int at_stop;
		int got;
		int fall;
		begin_test("stop");
		base = edge_cnt[0];
		set_cmd(0, 40, 15, 1'b1);
		pulse_start(2'b01);
		wait_edges(0, base + 5);
		at_stop = edge_cnt[0] - base;
		@(posedge clk);
		s_stop[0] <= 1'b1;
		@(posedge clk);
		s_stop[0] <= 1'b0;
		wait_idle(0);
		fall = cycle;
		got = edge_cnt[0] - base;
		check_count_range("pulses", NW'(at_stop + 1),
			NW'((at_stop + 2 < 40) ? at_stop + 2 : 39), NW'(got));
		if (got > 0)
			check_period("state fall after last step", SW'(step_clocks(got - 1, 40, 15)),
				SW'(fall - edge_cyc[0][edge_cnt[0] - 1]));
		end_test();
	endtask

	task automatic homing();
		int base;
		begin_test("homing");
		base = edge_cnt[0];
		set_cmd(0, 100, 15, 1'b0);
		pulse_start(2'b01);
		wait_edges(0, base + 3);
		@(posedge clk);
		m_zpd[0] <= 1'b1;
		wait_idle(0);
		check_count_range("pulses", NW'(3), NW'(99), NW'(edge_cnt[0] - base));
		check_bit("dir", 1'b0, m_dir[0]);
		check_bit("zpsign", 1'b1, s_zpsign[0]);
		check_bit("tpsign", 1'b0, s_tpsign[0]);
		@(posedge clk);
		m_zpd[0] <= 1'b0;
		repeat (10) @(negedge clk);
		check_bit("zpsign released", 1'b0, s_zpsign[0]);
		end_test();
	endtask

	task automatic stroke_limit();
		int base;
		begin_test("stroke");
		base = edge_cnt[0];
		@(posedge clk);
		s_stroke[0] <= NW'(7);
		set_cmd(0, 20, 15, 1'b1);
		pulse_start(2'b01);
		wait_idle(0);
		check_count("pulses", NW'(7), NW'(edge_cnt[0] - base));
		check_bit("tpsign", 1'b1, s_tpsign[0]);
		@(posedge clk);
		s_stroke[0] <= '1;
		end_test();
	endtask

	task automatic two_motors();
		int base [MOTOR_NBR];
		int n [MOTOR_NBR];
		int cap [MOTOR_NBR];
		begin_test("two motors");
		for (int m = 0; m < MOTOR_NBR; m++) begin
			base[m] = edge_cnt[m];
			n[m] = int'($urandom % 20) + 1;
			cap[m] = int'($urandom % 16);
			set_cmd(m, n[m], cap[m], 1'b1);
		end
		pulse_start('1);
		for (int m = 0; m < MOTOR_NBR; m++)
			wait_idle(m);
		for (int m = 0; m < MOTOR_NBR; m++) begin
			check_count($sformatf("motor %0d pulses", m), NW'(n[m]), NW'(edge_cnt[m] - base[m]));
			check_ms($sformatf("motor %0d microstep", m), MW'(m + 1), m_ms[m]);
			if (edge_cnt[m] - base[m] == n[m])
				check_intervals(m, base[m], n[m], cap[m]);
		end
		end_test();
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns", WATCHDOG_NS);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'hcb6));
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		resetn <= 1'b0;
		br_init <= 1'b0;
		br_wr_en <= 1'b0;
		br_data <= '0;
		m_zpd <= '0;
		s_stroke[0] <= '1;
		s_stroke[1] <= '1;
		s_cmd[0] <= '0;
		s_cmd[1] <= '0;
		s_start <= '0;
		s_stop <= '0;
		s_xen <= '0;
		s_xrst <= '0;
		repeat (3) @(posedge clk);
		resetn <= 1'b1;
		s_xen <= '1;
		load_table();
		single_move();
		profile_timing();
		stop_mid_move();
		homing();
		stroke_limit();
		two_motors();
		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
			checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/stepper_pkg.sv
hdl/speed_table.sv
hdl/motion_sequencer.sv
hdl/pulse_generator.sv
hdl/step_motor.sv
dv/step_motor_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP := step_motor_tb
FILELIST := project.f
OBJ_DIR := obj_dir
SIM := $(OBJ_DIR)/V$(TOP)

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) hdl/stepper_defines.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
